//--- design/fsab_pkg.sv
`default_nettype none

package fsab_pkg;

	// Request kind, one bit on the bus
	typedef enum logic {
		FSAB_READ  = 1'b0,
		FSAB_WRITE = 1'b1
	} fsab_mode_t;

	typedef logic [3:0]  fsab_did_t;   // Device id and sub-id
	typedef logic [30:0] fsab_addr_t;  // Word address
	typedef logic [3:0]  fsab_len_t;   // Write beat count
	typedef logic [63:0] fsab_data_t;
	typedef logic [7:0]  fsab_mask_t;  // One bit per data byte

	// Longest write burst
	localparam int FSAB_LEN_MAX = 8;

	// Requests a master may have in flight
	localparam int FSAB_INITIAL_CREDITS = 4;

	// Credit and header FIFO position counter
	// Extra top bit over the 4-entry index tells full from empty
	typedef logic [2:0] fsab_credits_t;

endpackage

`default_nettype wire

//--- design/fsab_arb_pkg.sv
`default_nettype none

package fsab_arb_pkg;

	localparam int ARB_NUM_MASTERS = 3;  // Request buffers behind the arbiter

	typedef logic [1:0] arb_idx_t;       // Master number

	// Worst case every credit is a full-length write
	localparam int ARB_DFIF_DEPTH = fsab_pkg::FSAB_INITIAL_CREDITS * fsab_pkg::FSAB_LEN_MAX;

	typedef logic [5:0] dfif_ptr_t;      // 32 entries plus wrap bit

	// Grant FSM
	typedef enum logic [1:0] {
		ARB_IDLE,   // Looking for a non-empty buffer
		ARB_START,  // Pulse start_trans to the winner
		ARB_BUSY    // Winner owns the bus until active drops
	} arb_state_t;

endpackage

`default_nettype wire

//--- design/fsab_credit_sync.sv
`default_nettype none

module fsab_credit_sync (
	input  wire  iclk,
	input  wire  iclk_rst_b,
	input  wire  oclk,
	input  wire  oclk_rst_b,
	input  wire  credit_rel,   // Release strobe, oclk domain
	output logic inp_credit    // Credit return pulse, iclk domain
);
	import fsab_pkg::*;

	fsab_credits_t rel_cnt;       // Releases counted on oclk
	fsab_credits_t rel_cnt_next;
	fsab_credits_t rel_gray;      // Flopped on oclk so decode glitches never cross
	fsab_credits_t rel_gray_s1;   // First iclk stage, may go metastable
	fsab_credits_t rel_gray_s2;
	fsab_credits_t ret_cnt;       // Credits already handed back
	fsab_credits_t ret_gray;

	assign rel_cnt_next = credit_rel ? rel_cnt + 1'b1 : rel_cnt;
	assign ret_gray     = (ret_cnt >> 1) ^ ret_cnt;

	// Behind the release count means one more credit owed
	assign inp_credit = (rel_gray_s2 != ret_gray);

	always_ff @(posedge oclk or negedge oclk_rst_b) begin
		if (!oclk_rst_b) begin
			rel_cnt  <= '0;
			rel_gray <= '0;
		end else begin
			rel_cnt  <= rel_cnt_next;
			rel_gray <= (rel_cnt_next >> 1) ^ rel_cnt_next;  // Gray of the new count
		end
	end

	always_ff @(posedge iclk or negedge iclk_rst_b) begin
		if (!iclk_rst_b) begin
			rel_gray_s1 <= '0;
			rel_gray_s2 <= '0;
			ret_cnt     <= '0;
		end else begin
			rel_gray_s1 <= rel_gray;
			rel_gray_s2 <= rel_gray_s1;
			if (inp_credit)
				ret_cnt <= ret_cnt + 1'b1;  // One step per pulse
		end
	end

endmodule

`default_nettype wire

//--- design/fsab_req_fifo.sv
`default_nettype none

module fsab_req_fifo (
	input  wire                  iclk,
	input  wire                  iclk_rst_b,
	input  wire                  oclk,
	input  wire                  oclk_rst_b,
	input  wire                  inp_valid,
	input  wire fsab_pkg::fsab_mode_t inp_mode,
	input  wire fsab_pkg::fsab_did_t  inp_did,
	input  wire fsab_pkg::fsab_did_t  inp_subdid,
	input  wire fsab_pkg::fsab_addr_t inp_addr,
	input  wire fsab_pkg::fsab_len_t  inp_len,
	input  wire fsab_pkg::fsab_data_t inp_data,
	input  wire fsab_pkg::fsab_mask_t inp_mask,
	input  wire                  start_trans,  // From arbiter, oclk
	output logic                 inp_credit,
	output logic                 out_valid,
	output fsab_pkg::fsab_mode_t out_mode,
	output fsab_pkg::fsab_did_t  out_did,
	output fsab_pkg::fsab_did_t  out_subdid,
	output fsab_pkg::fsab_addr_t out_addr,
	output fsab_pkg::fsab_len_t  out_len,
	output fsab_pkg::fsab_data_t out_data,
	output fsab_pkg::fsab_mask_t out_mask,
	output logic                 empty_b,      // A header is waiting
	output logic                 active        // Packet in progress
);
	import fsab_pkg::*;
	import fsab_arb_pkg::*;

	typedef logic [$bits(fsab_mode_t) + 2 * $bits(fsab_did_t) + $bits(fsab_addr_t)
		+ $bits(fsab_len_t) - 1:0] rfif_word_t;
	typedef logic [$bits(fsab_data_t) + $bits(fsab_mask_t) - 1:0] dfif_word_t;

	rfif_word_t    rfif_mem [FSAB_INITIAL_CREDITS];  // Header FIFO
	dfif_word_t    dfif_mem [ARB_DFIF_DEPTH];        // Data FIFO, every beat
	fsab_credits_t rfif_wpos;
	fsab_credits_t rfif_wpos_next;
	fsab_credits_t rfif_wgray;      // iclk copy for crossing
	fsab_credits_t rfif_wgray_s1;
	fsab_credits_t rfif_wgray_s2;   // Safe on oclk
	fsab_credits_t rfif_rpos;
	dfif_ptr_t     dfif_wpos;
	dfif_ptr_t     dfif_wpos_next;
	dfif_ptr_t     dfif_wgray;
	dfif_ptr_t     dfif_wgray_s1;
	dfif_ptr_t     dfif_wgray_s2;
	dfif_ptr_t     dfif_rpos;
	fsab_len_t     in_rem;          // Beats still owed by the current write
	logic          hdr_wr;          // First beat of a request
	logic          dfif_avail;
	logic          rfif_rd;
	logic          dfif_rd;
	logic          cont_rd;         // Read of a beat after the first
	logic          hdr_rd_q;        // Header just landed in hdr_q
	logic          active_q;
	logic          credit_rel;
	fsab_len_t     rem;             // Beats left to read after the first
	fsab_len_t     first_rem;
	fsab_len_t     cur_rem;
	rfif_word_t    hdr_q;
	dfif_word_t    dat_q;
	logic [$bits(fsab_mode_t) - 1:0] hdr_mode;

	// Input side, iclk
	assign hdr_wr         = inp_valid && (in_rem == '0);
	assign rfif_wpos_next = hdr_wr ? rfif_wpos + 1'b1 : rfif_wpos;
	assign dfif_wpos_next = inp_valid ? dfif_wpos + 1'b1 : dfif_wpos;  // Reads too

	always_ff @(posedge iclk or negedge iclk_rst_b) begin
		if (!iclk_rst_b) begin
			rfif_wpos  <= '0;
			dfif_wpos  <= '0;
			rfif_wgray <= '0;
			dfif_wgray <= '0;
			in_rem     <= '0;
		end else begin
			rfif_wpos  <= rfif_wpos_next;
			dfif_wpos  <= dfif_wpos_next;
			rfif_wgray <= (rfif_wpos_next >> 1) ^ rfif_wpos_next;
			dfif_wgray <= (dfif_wpos_next >> 1) ^ dfif_wpos_next;
			if (hdr_wr)
				in_rem <= (inp_mode == FSAB_WRITE && inp_len != '0) ? inp_len - 1'b1 : '0;
			else if (inp_valid)
				in_rem <= in_rem - 1'b1;
		end
	end

	always_ff @(posedge iclk) begin
		if (hdr_wr)
			rfif_mem[rfif_wpos[$bits(fsab_credits_t) - 2:0]] <=
				{inp_mode, inp_did, inp_subdid, inp_addr, inp_len};
		if (inp_valid)
			dfif_mem[dfif_wpos[$bits(dfif_ptr_t) - 2:0]] <= {inp_data, inp_mask};
	end

	// Both write pointers cross on the same edges
	// so a header is never seen ahead of its first beat
	always_ff @(posedge oclk or negedge oclk_rst_b) begin
		if (!oclk_rst_b) begin
			rfif_wgray_s1 <= '0;
			rfif_wgray_s2 <= '0;
			dfif_wgray_s1 <= '0;
			dfif_wgray_s2 <= '0;
		end else begin
			rfif_wgray_s1 <= rfif_wgray;
			rfif_wgray_s2 <= rfif_wgray_s1;
			dfif_wgray_s1 <= dfif_wgray;
			dfif_wgray_s2 <= dfif_wgray_s1;
		end
	end

	// Readout, oclk
	assign empty_b    = (rfif_wgray_s2 != ((rfif_rpos >> 1) ^ rfif_rpos));
	assign dfif_avail = (dfif_wgray_s2 != ((dfif_rpos >> 1) ^ dfif_rpos));

	assign first_rem = (out_mode == FSAB_WRITE && out_len != '0) ? out_len - 1'b1 : '0;
	assign cur_rem   = hdr_rd_q ? first_rem : rem;  // Length is known once header lands
	assign rfif_rd   = start_trans && empty_b && !active;
	assign cont_rd   = (cur_rem != '0) && dfif_avail;
	assign dfif_rd   = rfif_rd || cont_rd;           // Header always takes its first beat

	assign active     = hdr_rd_q || (rem != '0) || out_valid;
	assign credit_rel = active_q && !active;         // Packet fully drained

	always_ff @(posedge oclk or negedge oclk_rst_b) begin
		if (!oclk_rst_b) begin
			rfif_rpos <= '0;
			dfif_rpos <= '0;
			hdr_rd_q  <= 1'b0;
			out_valid <= 1'b0;
			rem       <= '0;
			active_q  <= 1'b0;
		end else begin
			if (rfif_rd)
				rfif_rpos <= rfif_rpos + 1'b1;
			if (dfif_rd)
				dfif_rpos <= dfif_rpos + 1'b1;
			hdr_rd_q  <= rfif_rd;
			out_valid <= dfif_rd;  // Beat shows one cycle after its read
			rem       <= cont_rd ? cur_rem - 1'b1 : cur_rem;
			active_q  <= active;
		end
	end

	always_ff @(posedge oclk) begin
		if (rfif_rd)
			hdr_q <= rfif_mem[rfif_rpos[$bits(fsab_credits_t) - 2:0]];
		if (dfif_rd)
			dat_q <= dfif_mem[dfif_rpos[$bits(dfif_ptr_t) - 2:0]];
	end

	assign {hdr_mode, out_did, out_subdid, out_addr, out_len} = hdr_q;
	assign out_mode             = fsab_mode_t'(hdr_mode);
	assign {out_data, out_mask} = dat_q;  // Read beats carry junk data too

	fsab_credit_sync u_credit_sync (
		.iclk       (iclk),
		.iclk_rst_b (iclk_rst_b),
		.oclk       (oclk),
		.oclk_rst_b (oclk_rst_b),
		.credit_rel (credit_rel),
		.inp_credit (inp_credit)
	);

endmodule

`default_nettype wire

//--- design/fsab_arbiter.sv
`default_nettype none

module fsab_arbiter (
	input  wire oclk,
	input  wire oclk_rst_b,
	input  wire [fsab_arb_pkg::ARB_NUM_MASTERS - 1:0] empty_b,
	input  wire [fsab_arb_pkg::ARB_NUM_MASTERS - 1:0] active,
	input  wire [fsab_arb_pkg::ARB_NUM_MASTERS - 1:0] fifo_valid,
	input  wire fsab_pkg::fsab_mode_t fifo_mode   [fsab_arb_pkg::ARB_NUM_MASTERS],
	input  wire fsab_pkg::fsab_did_t  fifo_did    [fsab_arb_pkg::ARB_NUM_MASTERS],
	input  wire fsab_pkg::fsab_did_t  fifo_subdid [fsab_arb_pkg::ARB_NUM_MASTERS],
	input  wire fsab_pkg::fsab_addr_t fifo_addr   [fsab_arb_pkg::ARB_NUM_MASTERS],
	input  wire fsab_pkg::fsab_len_t  fifo_len    [fsab_arb_pkg::ARB_NUM_MASTERS],
	input  wire fsab_pkg::fsab_data_t fifo_data   [fsab_arb_pkg::ARB_NUM_MASTERS],
	input  wire fsab_pkg::fsab_mask_t fifo_mask   [fsab_arb_pkg::ARB_NUM_MASTERS],
	output logic [fsab_arb_pkg::ARB_NUM_MASTERS - 1:0] start_trans,
	output logic                 out_valid,
	output fsab_pkg::fsab_mode_t out_mode,
	output fsab_pkg::fsab_did_t  out_did,
	output fsab_pkg::fsab_did_t  out_subdid,
	output fsab_pkg::fsab_addr_t out_addr,
	output fsab_pkg::fsab_len_t  out_len,
	output fsab_pkg::fsab_data_t out_data,
	output fsab_pkg::fsab_mask_t out_mask
);
	import fsab_pkg::*;
	import fsab_arb_pkg::*;

	arb_state_t state;
	arb_idx_t   grant;  // Current owner, or last one when idle
	arb_idx_t   pick;   // Next owner in round-robin order

	// Walk backwards so the nearest master after grant wins
	// grant itself comes last, so a lone busy master still gets served
	always_comb begin
		pick = grant;
		for (int i = ARB_NUM_MASTERS; i >= 1; i--) begin
			if (empty_b[(int'(grant) + i) % ARB_NUM_MASTERS])
				pick = arb_idx_t'((int'(grant) + i) % ARB_NUM_MASTERS);
		end
	end

	always_ff @(posedge oclk or negedge oclk_rst_b) begin
		if (!oclk_rst_b) begin
			state <= ARB_IDLE;
			grant <= arb_idx_t'(ARB_NUM_MASTERS - 1);  // Master 0 goes first
		end else begin
			case (state)
				ARB_IDLE: begin
					if (|empty_b) begin
						grant <= pick;
						state <= ARB_START;
					end
				end
				ARB_START: begin
					state <= ARB_BUSY;  // FIFO is active from the next cycle
				end
				ARB_BUSY: begin
					if (!active[grant])
						state <= ARB_IDLE;
				end
				default: begin
					state <= ARB_IDLE;
				end
			endcase
		end
	end

	// One-cycle kick to the winner
	always_comb begin
		start_trans = '0;
		if (state == ARB_START)
			start_trans[grant] = 1'b1;
	end

	// Output mux follows the grant
	assign out_valid  = fifo_valid[grant] && (state == ARB_BUSY);
	assign out_mode   = fifo_mode[grant];
	assign out_did    = fifo_did[grant];
	assign out_subdid = fifo_subdid[grant];
	assign out_addr   = fifo_addr[grant];
	assign out_len    = fifo_len[grant];
	assign out_data   = fifo_data[grant];
	assign out_mask   = fifo_mask[grant];

endmodule

`default_nettype wire

//--- design/fsab_arb.sv
`default_nettype none

module fsab_arb (
	input  wire [fsab_arb_pkg::ARB_NUM_MASTERS - 1:0] iclk,
	input  wire [fsab_arb_pkg::ARB_NUM_MASTERS - 1:0] iclk_rst_b,
	input  wire oclk,
	input  wire oclk_rst_b,
	input  wire [fsab_arb_pkg::ARB_NUM_MASTERS - 1:0] inp_valid,
	input  wire fsab_pkg::fsab_mode_t inp_mode   [fsab_arb_pkg::ARB_NUM_MASTERS],
	input  wire fsab_pkg::fsab_did_t  inp_did    [fsab_arb_pkg::ARB_NUM_MASTERS],
	input  wire fsab_pkg::fsab_did_t  inp_subdid [fsab_arb_pkg::ARB_NUM_MASTERS],
	input  wire fsab_pkg::fsab_addr_t inp_addr   [fsab_arb_pkg::ARB_NUM_MASTERS],
	input  wire fsab_pkg::fsab_len_t  inp_len    [fsab_arb_pkg::ARB_NUM_MASTERS],
	input  wire fsab_pkg::fsab_data_t inp_data   [fsab_arb_pkg::ARB_NUM_MASTERS],
	input  wire fsab_pkg::fsab_mask_t inp_mask   [fsab_arb_pkg::ARB_NUM_MASTERS],
	output wire [fsab_arb_pkg::ARB_NUM_MASTERS - 1:0] inp_credit,
	output logic                 out_valid,
	output fsab_pkg::fsab_mode_t out_mode,
	output fsab_pkg::fsab_did_t  out_did,
	output fsab_pkg::fsab_did_t  out_subdid,
	output fsab_pkg::fsab_addr_t out_addr,
	output fsab_pkg::fsab_len_t  out_len,
	output fsab_pkg::fsab_data_t out_data,
	output fsab_pkg::fsab_mask_t out_mask
);
	import fsab_pkg::*;
	import fsab_arb_pkg::*;

	// FIFO to arbiter, all oclk
	wire [ARB_NUM_MASTERS - 1:0] empty_b;
	wire [ARB_NUM_MASTERS - 1:0] active;
	wire [ARB_NUM_MASTERS - 1:0] start_trans;
	wire [ARB_NUM_MASTERS - 1:0] fifo_valid;
	wire fsab_mode_t fifo_mode   [ARB_NUM_MASTERS];
	wire fsab_did_t  fifo_did    [ARB_NUM_MASTERS];
	wire fsab_did_t  fifo_subdid [ARB_NUM_MASTERS];
	wire fsab_addr_t fifo_addr   [ARB_NUM_MASTERS];
	wire fsab_len_t  fifo_len    [ARB_NUM_MASTERS];
	wire fsab_data_t fifo_data   [ARB_NUM_MASTERS];
	wire fsab_mask_t fifo_mask   [ARB_NUM_MASTERS];

	for (genvar m = 0; m < ARB_NUM_MASTERS; m++) begin : g_master
		fsab_req_fifo u_fifo (
			.iclk        (iclk[m]),        // Each master on its own clock
			.iclk_rst_b  (iclk_rst_b[m]),
			.oclk        (oclk),
			.oclk_rst_b  (oclk_rst_b),
			.inp_valid   (inp_valid[m]),
			.inp_mode    (inp_mode[m]),
			.inp_did     (inp_did[m]),
			.inp_subdid  (inp_subdid[m]),
			.inp_addr    (inp_addr[m]),
			.inp_len     (inp_len[m]),
			.inp_data    (inp_data[m]),
			.inp_mask    (inp_mask[m]),
			.start_trans (start_trans[m]),
			.inp_credit  (inp_credit[m]),
			.out_valid   (fifo_valid[m]),
			.out_mode    (fifo_mode[m]),
			.out_did     (fifo_did[m]),
			.out_subdid  (fifo_subdid[m]),
			.out_addr    (fifo_addr[m]),
			.out_len     (fifo_len[m]),
			.out_data    (fifo_data[m]),
			.out_mask    (fifo_mask[m]),
			.empty_b     (empty_b[m]),
			.active      (active[m])
		);
	end

	fsab_arbiter u_arbiter (
		.oclk        (oclk),
		.oclk_rst_b  (oclk_rst_b),
		.empty_b     (empty_b),
		.active      (active),
		.fifo_valid  (fifo_valid),
		.fifo_mode   (fifo_mode),
		.fifo_did    (fifo_did),
		.fifo_subdid (fifo_subdid),
		.fifo_addr   (fifo_addr),
		.fifo_len    (fifo_len),
		.fifo_data   (fifo_data),
		.fifo_mask   (fifo_mask),
		.start_trans (start_trans),
		.out_valid   (out_valid),
		.out_mode    (out_mode),
		.out_did     (out_did),
		.out_subdid  (out_subdid),
		.out_addr    (out_addr),
		.out_len     (out_len),
		.out_data    (out_data),
		.out_mask    (out_mask)
	);

endmodule

`default_nettype wire

//--- dv/fsab_arb_tb.sv
`default_nettype none

module fsab_arb_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import fsab_pkg::*;
	import fsab_arb_pkg::*;

	localparam int      NUM_REQ     = 40;    // Requests per master
	localparam realtime FAIR_MARGIN = 40.0;  // Covers the header crossing into oclk

	logic [ARB_NUM_MASTERS - 1:0] iclk;
	logic [ARB_NUM_MASTERS - 1:0] iclk_rst_b;
	logic                         oclk;
	logic                         oclk_rst_b;
	logic [ARB_NUM_MASTERS - 1:0] inp_valid;
	fsab_mode_t inp_mode   [ARB_NUM_MASTERS];
	fsab_did_t  inp_did    [ARB_NUM_MASTERS];
	fsab_did_t  inp_subdid [ARB_NUM_MASTERS];
	fsab_addr_t inp_addr   [ARB_NUM_MASTERS];
	fsab_len_t  inp_len    [ARB_NUM_MASTERS];
	fsab_data_t inp_data   [ARB_NUM_MASTERS];
	fsab_mask_t inp_mask   [ARB_NUM_MASTERS];
	logic [ARB_NUM_MASTERS - 1:0] inp_credit;
	logic       out_valid;
	fsab_mode_t out_mode;
	fsab_did_t  out_did;
	fsab_did_t  out_subdid;
	fsab_addr_t out_addr;
	fsab_len_t  out_len;
	fsab_data_t out_data;
	fsab_mask_t out_mask;

	// Reference model, one slot per request
	fsab_mode_t exp_mode [ARB_NUM_MASTERS][NUM_REQ];
	fsab_did_t  exp_sub  [ARB_NUM_MASTERS][NUM_REQ];
	fsab_addr_t exp_addr [ARB_NUM_MASTERS][NUM_REQ];
	fsab_len_t  exp_len  [ARB_NUM_MASTERS][NUM_REQ];
	realtime    exp_time [ARB_NUM_MASTERS][NUM_REQ];  // When the header beat went out
	fsab_data_t exp_data [ARB_NUM_MASTERS][NUM_REQ][FSAB_LEN_MAX];
	fsab_mask_t exp_mask [ARB_NUM_MASTERS][NUM_REQ][FSAB_LEN_MAX];

	int          sent_cnt  [ARB_NUM_MASTERS];
	int          recv_cnt  [ARB_NUM_MASTERS];  // Packets fully seen on the output
	int          credits   [ARB_NUM_MASTERS];  // Held by each master
	int          ret_cnt   [ARB_NUM_MASTERS];  // Credit pulses seen
	logic [31:0] rng_state [ARB_NUM_MASTERS];
	int          check_cnt;
	int          err_cnt;
	int          pkt_cnt;

	fsab_arb dut0 (
		.iclk       (iclk),
		.iclk_rst_b (iclk_rst_b),
		.oclk       (oclk),
		.oclk_rst_b (oclk_rst_b),
		.inp_valid  (inp_valid),
		.inp_mode   (inp_mode),
		.inp_did    (inp_did),
		.inp_subdid (inp_subdid),
		.inp_addr   (inp_addr),
		.inp_len    (inp_len),
		.inp_data   (inp_data),
		.inp_mask   (inp_mask),
		.inp_credit (inp_credit),
		.out_valid  (out_valid),
		.out_mode   (out_mode),
		.out_did    (out_did),
		.out_subdid (out_subdid),
		.out_addr   (out_addr),
		.out_len    (out_len),
		.out_data   (out_data),
		.out_mask   (out_mask)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Separate stream per master
	function automatic logic [31:0] next_rand(input int m);
		rng_state[m] = xorshift32(rng_state[m]);
		return rng_state[m];
	endfunction

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		check_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act);
		end
	endtask

	task automatic report_error(input string msg);
		err_cnt++;
		$display("ERROR %s", msg);
	endtask

	task automatic check_reset_state();
		check_value("reset_out_valid", 64'd0, 64'(out_valid));
		check_value("reset_inp_credit", 64'd0, 64'(inp_credit));
	endtask

	// Repeat grant is only wrong if another master had a visible request
	task automatic check_round_robin(input int m, input realtime prev_hdr);
		for (int o = 0; o < ARB_NUM_MASTERS; o++) begin
			check_cnt++;
			if (o != m && recv_cnt[o] < sent_cnt[o]
				&& exp_time[o][recv_cnt[o]] + FAIR_MARGIN < prev_hdr)
				report_error($sformatf("master %0d granted twice while master %0d waited", m, o));
		end
	endtask

	function automatic logic all_received();
		for (int m = 0; m < ARB_NUM_MASTERS; m++)
			if (recv_cnt[m] != NUM_REQ)
				return 1'b0;
		return 1'b1;
	endfunction

	function automatic logic credits_full();
		for (int m = 0; m < ARB_NUM_MASTERS; m++)
			if (credits[m] != FSAB_INITIAL_CREDITS)
				return 1'b0;
		return 1'b1;
	endfunction

	initial begin
		oclk = 1'b0;
		forever #2 oclk = ~oclk;  // 4 ns
	end

	for (genvar g = 0; g < ARB_NUM_MASTERS; g++) begin : g_master
		initial begin
			iclk[g] = 1'b0;
			forever #((5.0 + g) / 2.0) iclk[g] = ~iclk[g];  // 5, 6 and 7 ns
		end

		// Master g, drives on the falling iclk edge
		initial begin
			logic [31:0] r;
			int          beats_left;
			int          beat_idx;
			int          req;
			inp_valid[g]  = 1'b0;
			inp_mode[g]   = FSAB_READ;
			inp_did[g]    = fsab_did_t'(g);  // did is the master index
			inp_subdid[g] = '0;
			inp_addr[g]   = '0;
			inp_len[g]    = '0;
			inp_data[g]   = '0;
			inp_mask[g]   = '0;
			beats_left    = 0;
			beat_idx      = 0;
			wait (iclk_rst_b[g] === 1'b1);
			forever begin
				@(negedge iclk[g]);
				if (inp_credit[g]) begin  // One credit per high cycle
					credits[g]++;
					ret_cnt[g]++;
					if (credits[g] > FSAB_INITIAL_CREDITS)
						report_error($sformatf("master %0d got more credits than it spent", g));
					if (ret_cnt[g] > recv_cnt[g])
						report_error($sformatf("master %0d got a credit before its packet left", g));
				end
				inp_valid[g] = 1'b0;
				r = next_rand(g);
				if (beats_left != 0) begin
					if (r[1:0] != 2'b00) begin  // Otherwise a gap cycle
						req = sent_cnt[g] - 1;
						inp_valid[g] = 1'b1;
						inp_data[g]  = {next_rand(g), next_rand(g)};
						inp_mask[g]  = r[15:8];
						exp_data[g][req][beat_idx] = inp_data[g];
						exp_mask[g][req][beat_idx] = inp_mask[g];
						beat_idx++;
						beats_left--;
					end
				end else if (sent_cnt[g] < NUM_REQ && credits[g] > 0 && r[0]) begin
					req = sent_cnt[g];
					inp_valid[g]  = 1'b1;
					inp_mode[g]   = r[1] ? FSAB_WRITE : FSAB_READ;
					inp_subdid[g] = r[7:4];
					inp_len[g]    = fsab_len_t'(r[10:8]) + 1'b1;  // 1 to 8, reads too
					inp_addr[g]   = fsab_addr_t'(next_rand(g));
					inp_data[g]   = {next_rand(g), next_rand(g)};
					inp_mask[g]   = r[23:16];
					exp_mode[g][req]    = inp_mode[g];
					exp_sub[g][req]     = inp_subdid[g];
					exp_addr[g][req]    = inp_addr[g];
					exp_len[g][req]     = inp_len[g];
					exp_time[g][req]    = $realtime;
					exp_data[g][req][0] = inp_data[g];
					exp_mask[g][req][0] = inp_mask[g];
					credits[g]--;
					sent_cnt[g]++;
					beat_idx   = 1;
					beats_left = (inp_mode[g] == FSAB_WRITE) ? int'(inp_len[g]) - 1 : 0;
				end
			end
		end
	end

	// Output monitor, oclk outputs are settled at the falling edge
	initial begin
		int      beat_no;
		int      cur_m;
		int      cur_beats;
		int      last_m;
		int      idx;
		realtime prev_hdr;
		string   tag;
		beat_no   = 0;
		cur_m     = 0;
		cur_beats = 0;
		last_m    = -1;
		idx       = 0;
		prev_hdr  = 0.0;
		forever begin
			@(negedge oclk);
			if (oclk_rst_b === 1'b1 && out_valid === 1'b1) begin
				if (beat_no == 0) begin  // Header beat
					cur_m = int'(out_did);
					if (cur_m >= ARB_NUM_MASTERS || recv_cnt[cur_m] >= sent_cnt[cur_m]) begin
						report_error($sformatf("packet from did %0d with no pending request",
							out_did));
						cur_beats = 0;
					end else begin
						idx = recv_cnt[cur_m];
						tag = $sformatf("m%0d_req%0d", cur_m, idx);
						if (cur_m == last_m)
							check_round_robin(cur_m, prev_hdr);
						check_value({tag, "_mode"}, 64'(exp_mode[cur_m][idx]), 64'(out_mode));
						check_value({tag, "_subdid"}, 64'(exp_sub[cur_m][idx]), 64'(out_subdid));
						check_value({tag, "_addr"}, 64'(exp_addr[cur_m][idx]), 64'(out_addr));
						check_value({tag, "_len"}, 64'(exp_len[cur_m][idx]), 64'(out_len));
						cur_beats = (exp_mode[cur_m][idx] == FSAB_WRITE) ?
							int'(exp_len[cur_m][idx]) : 1;
						last_m   = cur_m;
						prev_hdr = $realtime;
					end
				end else if (int'(out_did) != cur_m) begin
					report_error($sformatf("beat from did %0d inside a packet of master %0d",
						out_did, cur_m));
				end
				if (cur_beats != 0) begin
					if (exp_mode[cur_m][idx] == FSAB_WRITE) begin  // Read data is don't care
						tag = $sformatf("m%0d_req%0d_beat%0d", cur_m, idx, beat_no);
						check_value({tag, "_data"}, exp_data[cur_m][idx][beat_no], out_data);
						check_value({tag, "_mask"}, 64'(exp_mask[cur_m][idx][beat_no]),
							64'(out_mask));
					end
					beat_no++;
					if (beat_no == cur_beats) begin  // Packet complete
						recv_cnt[cur_m]++;
						pkt_cnt++;
						beat_no   = 0;
						cur_beats = 0;
					end
				end
			end
		end
	end

	// Watchdog
	initial begin
		repeat (ARB_NUM_MASTERS * NUM_REQ * 200) @(posedge oclk);
		$display("Timeout, only %0d of %0d packets came out", pkt_cnt, ARB_NUM_MASTERS * NUM_REQ);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		oclk_rst_b = 1'b0;
		iclk_rst_b = '0;
		check_cnt  = 0;
		err_cnt    = 0;
		pkt_cnt    = 0;
		for (int m = 0; m < ARB_NUM_MASTERS; m++) begin
			sent_cnt[m]  = 0;
			recv_cnt[m]  = 0;
			ret_cnt[m]   = 0;
			credits[m]   = FSAB_INITIAL_CREDITS;  // Known after reset
			rng_state[m] = 32'd21 + 32'(m) * 32'h9e37_79b9;
		end
		repeat (3) begin
			@(negedge oclk);
			check_reset_state();
		end
		oclk_rst_b = 1'b1;
		iclk_rst_b = '1;
		@(negedge oclk);
		check_reset_state();  // First cycle out of reset
		while (!all_received())
			@(negedge oclk);
		// Last credits still crossing into iclk
		for (int i = 0; i < 100 && !credits_full(); i++)
			@(negedge oclk);
		for (int m = 0; m < ARB_NUM_MASTERS; m++)
			check_value($sformatf("m%0d_credits_after_drain", m),
				64'(FSAB_INITIAL_CREDITS), 64'(credits[m]));
		$display("checks %0d, errors %0d, packets %0d", check_cnt, err_cnt, pkt_cnt);
		if (err_cnt == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- fsab_arb.f
design/fsab_pkg.sv
design/fsab_arb_pkg.sv
design/fsab_credit_sync.sv
design/fsab_req_fifo.sv
design/fsab_arbiter.sv
design/fsab_arb.sv
dv/fsab_arb_tb.sv

//--- Bender.yml
package:
  name: fsab_arb

sources:
  - design/fsab_pkg.sv
  - design/fsab_arb_pkg.sv
  - design/fsab_credit_sync.sv
  - design/fsab_req_fifo.sv
  - design/fsab_arbiter.sv
  - design/fsab_arb.sv
  - target: test
    files:
      - dv/fsab_arb_tb.sv
